/* compile.f */
logic/axi_complex_pkg.sv
logic/axi_ep_if.sv
logic/axi_ep_tracker.sv
logic/axi_complex_router.sv
logic/axi_sram_ep.sv
logic/axi_fifo_ep.sv
logic/axi_complex_top.sv
verification/axi_complex_tb.sv

/* Bender.yml */
package:
  name: axi_complex

sources:
  - logic/axi_complex_pkg.sv
  - logic/axi_ep_if.sv
  - logic/axi_ep_tracker.sv
  - logic/axi_complex_router.sv
  - logic/axi_sram_ep.sv
  - logic/axi_fifo_ep.sv
  - logic/axi_complex_top.sv
  - target: test
    files:
      - verification/axi_complex_tb.sv

/* verification/axi_complex_tb.sv */
// Only one operation is in flight at a time, and an unmapped address runs into the timeout
`timescale 1ns/1ps

module axi_complex_tb;

    localparam int NUM_OPS        = 400;
    localparam int SRAM_WORDS     = 2**(axi_complex_pkg::SRAM_ADDR_W-2);
    localparam int DIRECTED_OPS   = SRAM_WORDS + axi_complex_pkg::FIFO_DEPTH + 8;
    localparam int MAX_STALL      = 4;
    // Every operation finishes well within 12 cycles even at the longest stall
    localparam int TIMEOUT_CYCLES = (NUM_OPS + DIRECTED_OPS) * 12 + 10;

    logic                   core_clk;
    logic                   cptra_rst_b;
    logic                   i_arvalid, o_arready, o_rvalid, i_rready;
    axi_complex_pkg::addr_t i_araddr, i_awaddr;
    axi_complex_pkg::id_t   i_arid, o_rid, i_awid, o_bid;
    axi_complex_pkg::data_t o_rdata, i_wdata;
    axi_complex_pkg::resp_t o_rresp, o_bresp;
    logic                   i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
    axi_complex_pkg::strb_t i_wstrb;
    logic                   i_fifo_clear, o_fifo_data_avail;

    // Reference model
    axi_complex_pkg::data_t sram_model [SRAM_WORDS];
    axi_complex_pkg::data_t fifo_model [$];

    logic [31:0] seed;
    int          errors;
    int          checks;
    int          cycle_count = 0;

    axi_complex_top axi_complex_top_inst (.*);

    always #20 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Initial SRAM contents unique per word address
    function automatic axi_complex_pkg::data_t fill_word(input logic [7:0] idx);
        return {8'ha5 ^ idx, idx, ~idx, idx + 8'h3c};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic bus_read(input axi_complex_pkg::addr_t addr, input axi_complex_pkg::id_t id,
                            input int stall, input axi_complex_pkg::data_t exp_data,
                            input axi_complex_pkg::resp_t exp_resp);
        int k;
        @(posedge core_clk);
        i_arvalid <= 1'b1;
        i_araddr  <= addr;
        i_arid    <= id;
        @(negedge core_clk);
        while (!o_arready) begin
            @(negedge core_clk);
        end
        // AR transfer on this edge
        @(posedge core_clk);
        i_arvalid <= 1'b0;
        i_rready  <= (stall == 0);
        @(negedge core_clk);
        check_value("rvalid_latency", 1'b1, o_rvalid);
        check_value("rid", id, o_rid);
        check_value("rdata", exp_data, o_rdata);
        check_value("rresp", exp_resp, o_rresp);
        // A held R response blocks the next read
        check_value("arready_blocked", 1'b0, o_arready);
        for (k = 0; k < stall; k++) begin
            @(posedge core_clk);
            if (k == stall - 1) begin
                i_rready <= 1'b1;
            end
            @(negedge core_clk);
            check_value("rvalid_held", 1'b1, o_rvalid);
            check_value("rdata_held", exp_data, o_rdata);
            check_value("rresp_held", exp_resp, o_rresp);
            check_value("arready_held", 1'b0, o_arready);
        end
        @(posedge core_clk);
        i_rready <= 1'b0;
    endtask

    task automatic bus_write(input axi_complex_pkg::addr_t addr, input axi_complex_pkg::id_t id,
                             input axi_complex_pkg::data_t data,
                             input axi_complex_pkg::strb_t strb,
                             input int stall, input axi_complex_pkg::resp_t exp_resp);
        int k;
        @(posedge core_clk);
        i_awvalid <= 1'b1;
        i_awaddr  <= addr;
        i_awid    <= id;
        i_wvalid  <= 1'b1;
        i_wdata   <= data;
        i_wstrb   <= strb;
        @(negedge core_clk);
        while (!o_awready) begin
            @(negedge core_clk);
        end
        @(posedge core_clk);
        i_awvalid <= 1'b0;
        @(negedge core_clk);
        while (!o_wready) begin
            @(negedge core_clk);
        end
        // W transfer on this edge and B one cycle later
        @(posedge core_clk);
        i_wvalid <= 1'b0;
        i_bready <= (stall == 0);
        @(negedge core_clk);
        check_value("bvalid_latency", 1'b1, o_bvalid);
        check_value("bid", id, o_bid);
        check_value("bresp", exp_resp, o_bresp);
        // A held B response blocks the next write
        check_value("awready_blocked", 1'b0, o_awready);
        check_value("wready_blocked", 1'b0, o_wready);
        for (k = 0; k < stall; k++) begin
            @(posedge core_clk);
            if (k == stall - 1) begin
                i_bready <= 1'b1;
            end
            @(negedge core_clk);
            check_value("bvalid_held", 1'b1, o_bvalid);
            check_value("bresp_held", exp_resp, o_bresp);
            check_value("bid_held", id, o_bid);
            check_value("awready_held", 1'b0, o_awready);
            check_value("wready_held", 1'b0, o_wready);
        end
        @(posedge core_clk);
        i_bready <= 1'b0;
    endtask

    task automatic sram_write(input logic [9:0] offset, input axi_complex_pkg::data_t data,
                              input axi_complex_pkg::strb_t strb);
        logic [31:0] r;
        int          i;
        r = next_rand();
        bus_write(axi_complex_pkg::SRAM_BASE_ADDR | offset, r[19:16], data, strb,
                  r[26:24] % (MAX_STALL + 1), axi_complex_pkg::RESP_OKAY);
        for (i = 0; i < 4; i++) begin
            if (strb[i]) begin
                sram_model[offset[9:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    task automatic sram_read(input logic [9:0] offset);
        logic [31:0] r;
        r = next_rand();
        bus_read(axi_complex_pkg::SRAM_BASE_ADDR | offset, r[19:16],
                 r[26:24] % (MAX_STALL + 1), sram_model[offset[9:2]],
                 axi_complex_pkg::RESP_OKAY);
    endtask

    task automatic fifo_write(input logic [11:0] offset, input axi_complex_pkg::data_t data);
        logic [31:0]            r;
        axi_complex_pkg::resp_t exp_resp;
        r = next_rand();
        exp_resp = (fifo_model.size() == axi_complex_pkg::FIFO_DEPTH) ?
                   axi_complex_pkg::RESP_SLVERR : axi_complex_pkg::RESP_OKAY;
        bus_write(axi_complex_pkg::FIFO_BASE_ADDR | offset, r[19:16], data, r[23:20],
                  r[26:24] % (MAX_STALL + 1), exp_resp);
        // A full FIFO loses the word
        if (exp_resp == axi_complex_pkg::RESP_OKAY) begin
            fifo_model.push_back(data);
        end
        @(negedge core_clk);
        check_value("fifo_data_avail", fifo_model.size() != 0, o_fifo_data_avail);
    endtask

    task automatic fifo_read(input logic [11:0] offset);
        logic [31:0]            r;
        axi_complex_pkg::data_t exp_data;
        axi_complex_pkg::resp_t exp_resp;
        r = next_rand();
        if (fifo_model.size() == 0) begin
            exp_data = '0;
            exp_resp = axi_complex_pkg::RESP_SLVERR;
        end else begin
            exp_data = fifo_model.pop_front();
            exp_resp = axi_complex_pkg::RESP_OKAY;
        end
        bus_read(axi_complex_pkg::FIFO_BASE_ADDR | offset, r[19:16],
                 r[26:24] % (MAX_STALL + 1), exp_data, exp_resp);
        @(negedge core_clk);
        check_value("fifo_data_avail", fifo_model.size() != 0, o_fifo_data_avail);
    endtask

    task automatic fifo_clear();
        @(posedge core_clk);
        i_fifo_clear <= 1'b1;
        @(posedge core_clk);
        i_fifo_clear <= 1'b0;
        fifo_model.delete();
        @(negedge core_clk);
        check_value("fifo_clear_avail", 1'b0, o_fifo_data_avail);
    endtask

    initial begin
        logic [31:0] r;
        int          n;
        seed         = 32'hc4dd82b6;
        errors       = 0;
        checks       = 0;
        core_clk     = 1'b0;
        cptra_rst_b  = 1'b0;
        i_arvalid    = 1'b0;
        i_araddr     = '0;
        i_arid       = '0;
        i_rready     = 1'b0;
        i_awvalid    = 1'b0;
        i_awaddr     = '0;
        i_awid       = '0;
        i_wvalid     = 1'b0;
        i_wdata      = '0;
        i_wstrb      = '0;
        i_bready     = 1'b0;
        i_fifo_clear = 1'b0;

        repeat (5) @(posedge core_clk);
        cptra_rst_b <= 1'b1;
        @(negedge core_clk);
        check_value("reset_rvalid", 1'b0, o_rvalid);
        check_value("reset_bvalid", 1'b0, o_bvalid);
        check_value("reset_data_avail", 1'b0, o_fifo_data_avail);

        // Known contents in every SRAM word
        for (n = 0; n < SRAM_WORDS; n++) begin
            sram_write(n * 4, fill_word(n), 4'hf);
        end

        // Push past full
        for (n = 0; n < axi_complex_pkg::FIFO_DEPTH + 2; n++) begin
            r = next_rand();
            fifo_write(r[11:0], next_rand());
        end

        for (n = 0; n < NUM_OPS; n++) begin
            r = next_rand();
            if (r[31:28] < 5) begin
                sram_write(r[9:0], next_rand(), r[13:10]);
            end else if (r[31:28] < 9) begin
                sram_read(r[9:0]);
            end else if (r[31:28] < 12) begin
                fifo_write(r[11:0], next_rand());
            end else if (r[31:28] < 15) begin
                fifo_read(r[11:0]);
            end else begin
                fifo_clear();
            end
        end

        // Read after clear must hit an empty FIFO
        fifo_clear();
        fifo_read(12'h0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* logic/axi_complex_top.sv */
// Latencies at these ports equal the endpoint latencies since the router path is combinational
`timescale 1ns/1ps

module axi_complex_top (
    input  logic                   core_clk,
    input  logic                   cptra_rst_b,

    // Read channels
    input  logic                   i_arvalid,
    output logic                   o_arready,
    input  axi_complex_pkg::addr_t i_araddr,
    input  axi_complex_pkg::id_t   i_arid,
    output logic                   o_rvalid,
    input  logic                   i_rready,
    output axi_complex_pkg::data_t o_rdata,
    output axi_complex_pkg::resp_t o_rresp,
    output axi_complex_pkg::id_t   o_rid,

    // Write channels
    input  logic                   i_awvalid,
    output logic                   o_awready,
    input  axi_complex_pkg::addr_t i_awaddr,
    input  axi_complex_pkg::id_t   i_awid,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    input  axi_complex_pkg::data_t i_wdata,
    input  axi_complex_pkg::strb_t i_wstrb,
    output logic                   o_bvalid,
    input  logic                   i_bready,
    output axi_complex_pkg::resp_t o_bresp,
    output axi_complex_pkg::id_t   o_bid,

    // FIFO control and status
    input  logic                   i_fifo_clear,
    output logic                   o_fifo_data_avail
);

    axi_ep_if #(.ADDR_W(axi_complex_pkg::SRAM_ADDR_W)) sram_if ();
    axi_ep_if #(.ADDR_W(axi_complex_pkg::FIFO_ADDR_W)) fifo_if ();

    // Manager ports share their names with the top ports
    axi_complex_router router_inst (
        .*,
        .sram (sram_if),
        .fifo (fifo_if)
    );

    axi_sram_ep sram_ep_inst (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .ep          (sram_if)
    );

    axi_fifo_ep fifo_ep_inst (
        .core_clk          (core_clk),
        .cptra_rst_b       (cptra_rst_b),
        .ep                (fifo_if),
        .i_fifo_clear      (i_fifo_clear),
        .o_fifo_data_avail (o_fifo_data_avail)
    );

endmodule

/* logic/axi_fifo_ep.sv */
// Address offset and strobes are ignored, and a push to a full FIFO is dropped with SLVERR
`timescale 1ns/1ps

module axi_fifo_ep (
    input  logic  core_clk,
    input  logic  cptra_rst_b,
    axi_ep_if.sub ep,
    input  logic  i_fifo_clear,
    output logic  o_fifo_data_avail
);

    axi_complex_pkg::data_t fifo_mem [axi_complex_pkg::FIFO_DEPTH];

    logic [$clog2(axi_complex_pkg::FIFO_DEPTH)-1:0]   wr_ptr, rd_ptr;
    logic [$clog2(axi_complex_pkg::FIFO_DEPTH+1)-1:0] count;
    logic                                             aw_pend;
    axi_complex_pkg::id_t                             aw_id;
    logic                                             ar_hs, aw_hs, w_hs;
    logic                                             push, pop, full, empty;

    assign ar_hs = ep.arvalid && ep.arready;
    assign aw_hs = ep.awvalid && ep.awready;
    assign w_hs  = ep.wvalid && ep.wready;

    assign full  = (count == axi_complex_pkg::FIFO_DEPTH);
    assign empty = (count == '0);
    assign push  = w_hs && !full;
    assign pop   = ar_hs && !empty;

    assign o_fifo_data_avail = !empty;

    // Same handshake rules as the SRAM endpoint
    assign ep.arready = !ep.rvalid;
    assign ep.awready = !aw_pend && !ep.bvalid;
    assign ep.wready  = aw_pend && !ep.bvalid;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            ep.rvalid <= 1'b0;
            ep.bvalid <= 1'b0;
            aw_pend   <= 1'b0;
        end else begin
            if (ar_hs) begin
                ep.rvalid <= 1'b1;
            end else if (ep.rready) begin
                ep.rvalid <= 1'b0;
            end
            if (aw_hs) begin
                aw_pend <= 1'b1;
            end else if (w_hs) begin
                aw_pend <= 1'b0;
            end
            if (w_hs) begin
                ep.bvalid <= 1'b1;
            end else if (ep.bready) begin
                ep.bvalid <= 1'b0;
            end
        end
    end

    // Clear wins over a push or pop in the same cycle
    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_fifo_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= ep.wdata;
        end
        // Empty read returns zero
        if (ar_hs) begin
            ep.rdata <= empty ? '0 : fifo_mem[rd_ptr];
            ep.rresp <= empty ? axi_complex_pkg::RESP_SLVERR : axi_complex_pkg::RESP_OKAY;
            ep.rid   <= ep.arid;
        end
        if (aw_hs) begin
            aw_id <= ep.awid;
        end
        if (w_hs) begin
            ep.bid   <= aw_id;
            ep.bresp <= full ? axi_complex_pkg::RESP_SLVERR : axi_complex_pkg::RESP_OKAY;
        end
    end

endmodule

/* logic/axi_sram_ep.sv */
// Word addressed with the two low offset bits ignored, and unwritten words read back as unknown
`timescale 1ns/1ps

module axi_sram_ep (
    input  logic  core_clk,
    input  logic  cptra_rst_b,
    axi_ep_if.sub ep
);

    axi_complex_pkg::data_t mem [2**(axi_complex_pkg::SRAM_ADDR_W-2)];

    logic                                    aw_pend;
    logic [axi_complex_pkg::SRAM_ADDR_W-1:2] aw_addr;
    axi_complex_pkg::id_t                    aw_id;
    logic                                    ar_hs, aw_hs, w_hs;

    assign ar_hs = ep.arvalid && ep.arready;
    assign aw_hs = ep.awvalid && ep.awready;
    assign w_hs  = ep.wvalid && ep.wready;

    // A held response blocks the request channels of its direction
    assign ep.arready = !ep.rvalid;
    assign ep.awready = !aw_pend && !ep.bvalid;
    assign ep.wready  = aw_pend && !ep.bvalid;

    assign ep.rresp = axi_complex_pkg::RESP_OKAY;
    assign ep.bresp = axi_complex_pkg::RESP_OKAY;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            ep.rvalid <= 1'b0;
            ep.bvalid <= 1'b0;
            aw_pend   <= 1'b0;
        end else begin
            if (ar_hs) begin
                ep.rvalid <= 1'b1;
            end else if (ep.rready) begin
                ep.rvalid <= 1'b0;
            end
            // One address latched, then wait for its data
            if (aw_hs) begin
                aw_pend <= 1'b1;
            end else if (w_hs) begin
                aw_pend <= 1'b0;
            end
            if (w_hs) begin
                ep.bvalid <= 1'b1;
            end else if (ep.bready) begin
                ep.bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (ar_hs) begin
            ep.rdata <= mem[ep.araddr[axi_complex_pkg::SRAM_ADDR_W-1:2]];
            ep.rid   <= ep.arid;
        end
        if (aw_hs) begin
            aw_addr <= ep.awaddr[axi_complex_pkg::SRAM_ADDR_W-1:2];
            aw_id   <= ep.awid;
        end
        if (w_hs) begin
            ep.bid <= aw_id;
            // Byte lanes under wstrb
            for (int i = 0; i < $bits(axi_complex_pkg::strb_t); i++) begin
                if (ep.wstrb[i]) begin
                    mem[aw_addr][8*i +: 8] <= ep.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* logic/axi_complex_router.sv */
// An address outside both windows is never accepted, so the manager must only issue mapped addresses
`timescale 1ns/1ps

module axi_complex_router (
    input  logic                   core_clk,
    input  logic                   cptra_rst_b,

    // Manager side
    input  logic                   i_arvalid,
    output logic                   o_arready,
    input  axi_complex_pkg::addr_t i_araddr,
    input  axi_complex_pkg::id_t   i_arid,
    output logic                   o_rvalid,
    input  logic                   i_rready,
    output axi_complex_pkg::data_t o_rdata,
    output axi_complex_pkg::resp_t o_rresp,
    output axi_complex_pkg::id_t   o_rid,
    input  logic                   i_awvalid,
    output logic                   o_awready,
    input  axi_complex_pkg::addr_t i_awaddr,
    input  axi_complex_pkg::id_t   i_awid,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    input  axi_complex_pkg::data_t i_wdata,
    input  axi_complex_pkg::strb_t i_wstrb,
    output logic                   o_bvalid,
    input  logic                   i_bready,
    output axi_complex_pkg::resp_t o_bresp,
    output axi_complex_pkg::id_t   o_bid,

    // Endpoint side
    axi_ep_if.mgr                  sram,
    axi_ep_if.mgr                  fifo
);

    logic sram_ar_hit, fifo_ar_hit, sram_aw_hit, fifo_aw_hit;
    logic sram_ar_ok, fifo_ar_ok, sram_aw_ok, fifo_aw_ok;
    logic sram_rd_active, sram_wr_active, sram_rd_room, sram_wr_room;
    logic fifo_rd_active, fifo_wr_active, fifo_rd_room, fifo_wr_room;

    // Window decode on the bits above each offset
    assign sram_ar_hit = (i_araddr[31:axi_complex_pkg::SRAM_ADDR_W] ==
                          axi_complex_pkg::SRAM_BASE_ADDR[31:axi_complex_pkg::SRAM_ADDR_W]);
    assign fifo_ar_hit = (i_araddr[31:axi_complex_pkg::FIFO_ADDR_W] ==
                          axi_complex_pkg::FIFO_BASE_ADDR[31:axi_complex_pkg::FIFO_ADDR_W]);
    assign sram_aw_hit = (i_awaddr[31:axi_complex_pkg::SRAM_ADDR_W] ==
                          axi_complex_pkg::SRAM_BASE_ADDR[31:axi_complex_pkg::SRAM_ADDR_W]);
    assign fifo_aw_hit = (i_awaddr[31:axi_complex_pkg::FIFO_ADDR_W] ==
                          axi_complex_pkg::FIFO_BASE_ADDR[31:axi_complex_pkg::FIFO_ADDR_W]);

    // Own tracker has room and the other endpoint is idle in that direction
    assign sram_ar_ok = sram_ar_hit && sram_rd_room && !fifo_rd_active;
    assign fifo_ar_ok = fifo_ar_hit && fifo_rd_room && !sram_rd_active;
    assign sram_aw_ok = sram_aw_hit && sram_wr_room && !fifo_wr_active;
    assign fifo_aw_ok = fifo_aw_hit && fifo_wr_room && !sram_wr_active;

    // SRAM fan-out
    assign sram.arvalid = i_arvalid && sram_ar_ok;
    assign sram.araddr  = i_araddr[axi_complex_pkg::SRAM_ADDR_W-1:0];
    assign sram.arid    = i_arid;
    assign sram.awvalid = i_awvalid && sram_aw_ok;
    assign sram.awaddr  = i_awaddr[axi_complex_pkg::SRAM_ADDR_W-1:0];
    assign sram.awid    = i_awid;
    assign sram.wvalid  = i_wvalid && sram_wr_active;
    assign sram.wdata   = i_wdata;
    assign sram.wstrb   = i_wstrb;
    assign sram.rready  = i_rready && sram_rd_active;
    assign sram.bready  = i_bready && sram_wr_active;

    // FIFO fan-out
    assign fifo.arvalid = i_arvalid && fifo_ar_ok;
    assign fifo.araddr  = i_araddr[axi_complex_pkg::FIFO_ADDR_W-1:0];
    assign fifo.arid    = i_arid;
    assign fifo.awvalid = i_awvalid && fifo_aw_ok;
    assign fifo.awaddr  = i_awaddr[axi_complex_pkg::FIFO_ADDR_W-1:0];
    assign fifo.awid    = i_awid;
    assign fifo.wvalid  = i_wvalid && fifo_wr_active;
    assign fifo.wdata   = i_wdata;
    assign fifo.wstrb   = i_wstrb;
    assign fifo.rready  = i_rready && fifo_rd_active;
    assign fifo.bready  = i_bready && fifo_wr_active;

    // Windows are disjoint, so at most one term is set
    assign o_arready = (sram.arready && sram_ar_ok) || (fifo.arready && fifo_ar_ok);
    assign o_awready = (sram.awready && sram_aw_ok) || (fifo.awready && fifo_aw_ok);
    assign o_wready  = (sram.wready && sram_wr_active) || (fifo.wready && fifo_wr_active);

    // Responses from whichever endpoint is active
    always_comb begin
        if (sram_rd_active) begin
            {o_rvalid, o_rdata, o_rresp, o_rid} = {sram.rvalid, sram.rdata, sram.rresp, sram.rid};
        end else if (fifo_rd_active) begin
            {o_rvalid, o_rdata, o_rresp, o_rid} = {fifo.rvalid, fifo.rdata, fifo.rresp, fifo.rid};
        end else begin
            {o_rvalid, o_rdata, o_rresp, o_rid} = '0;
        end
        if (sram_wr_active) begin
            {o_bvalid, o_bresp, o_bid} = {sram.bvalid, sram.bresp, sram.bid};
        end else if (fifo_wr_active) begin
            {o_bvalid, o_bresp, o_bid} = {fifo.bvalid, fifo.bresp, fifo.bid};
        end else begin
            {o_bvalid, o_bresp, o_bid} = '0;
        end
    end

    axi_ep_tracker sram_tracker_inst (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .i_ar_hs     (sram.arvalid && sram.arready),
        .i_r_hs      (sram.rvalid && sram.rready),
        .i_aw_hs     (sram.awvalid && sram.awready),
        .i_b_hs      (sram.bvalid && sram.bready),
        .o_rd_active (sram_rd_active),
        .o_wr_active (sram_wr_active),
        .o_rd_room   (sram_rd_room),
        .o_wr_room   (sram_wr_room)
    );

    axi_ep_tracker fifo_tracker_inst (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .i_ar_hs     (fifo.arvalid && fifo.arready),
        .i_r_hs      (fifo.rvalid && fifo.rready),
        .i_aw_hs     (fifo.awvalid && fifo.awready),
        .i_b_hs      (fifo.bvalid && fifo.bready),
        .o_rd_active (fifo_rd_active),
        .o_wr_active (fifo_wr_active),
        .o_rd_room   (fifo_rd_room),
        .o_wr_room   (fifo_wr_room)
    );

endmodule

/* logic/axi_ep_tracker.sv */
// Counts stay within the package limits only if the router holds off requests when room is low
`timescale 1ns/1ps

module axi_ep_tracker (
    input  logic core_clk,
    input  logic cptra_rst_b,
    input  logic i_ar_hs,
    input  logic i_r_hs,
    input  logic i_aw_hs,
    input  logic i_b_hs,
    output logic o_rd_active,
    output logic o_wr_active,
    output logic o_rd_room,
    output logic o_wr_room
);

    logic [$clog2(axi_complex_pkg::MAX_RD_OUTSTANDING+1)-1:0] rd_cnt;
    logic [$clog2(axi_complex_pkg::MAX_WR_OUTSTANDING+1)-1:0] wr_cnt;

    // Request and response in the same cycle cancel out
    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rd_cnt <= '0;
        end else if (i_ar_hs && !i_r_hs) begin
            rd_cnt <= rd_cnt + 1'b1;
        end else if (i_r_hs && !i_ar_hs) begin
            rd_cnt <= rd_cnt - 1'b1;
        end
    end

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_cnt <= '0;
        end else if (i_aw_hs && !i_b_hs) begin
            wr_cnt <= wr_cnt + 1'b1;
        end else if (i_b_hs && !i_aw_hs) begin
            wr_cnt <= wr_cnt - 1'b1;
        end
    end

    assign o_rd_active = (rd_cnt != '0);
    assign o_wr_active = (wr_cnt != '0);

    // No room once the limit is reached
    assign o_rd_room = (rd_cnt < axi_complex_pkg::MAX_RD_OUTSTANDING);
    assign o_wr_room = (wr_cnt < axi_complex_pkg::MAX_WR_OUTSTANDING);

endmodule

/* logic/axi_ep_if.sv */
// Address fields carry only the window offset, so ADDR_W has to match the window of the endpoint
`timescale 1ns/1ps

interface axi_ep_if #(
    parameter int ADDR_W = axi_complex_pkg::SRAM_ADDR_W
);

    // Read address and read data
    logic                   arvalid;
    logic                   arready;
    logic [ADDR_W-1:0]      araddr;
    axi_complex_pkg::id_t   arid;
    logic                   rvalid;
    logic                   rready;
    axi_complex_pkg::data_t rdata;
    axi_complex_pkg::resp_t rresp;
    axi_complex_pkg::id_t   rid;

    // Write address, write data and write response
    logic                   awvalid;
    logic                   awready;
    logic [ADDR_W-1:0]      awaddr;
    axi_complex_pkg::id_t   awid;
    logic                   wvalid;
    logic                   wready;
    axi_complex_pkg::data_t wdata;
    axi_complex_pkg::strb_t wstrb;
    logic                   bvalid;
    logic                   bready;
    axi_complex_pkg::resp_t bresp;
    axi_complex_pkg::id_t   bid;

    modport mgr (
        output arvalid, araddr, arid, awvalid, awaddr, awid,
        output wvalid, wdata, wstrb, rready, bready,
        input  arready, awready, wready,
        input  rvalid, rdata, rresp, rid, bvalid, bresp, bid
    );

    modport sub (
        input  arvalid, araddr, arid, awvalid, awaddr, awid,
        input  wvalid, wdata, wstrb, rready, bready,
        output arready, awready, wready,
        output rvalid, rdata, rresp, rid, bvalid, bresp, bid
    );

endinterface

/* logic/axi_complex_pkg.sv */
// Both windows must be aligned to their own size and must not overlap, and FIFO_DEPTH must be a power of two
package axi_complex_pkg;

    // Bus field types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  id_t;
    typedef logic [1:0]  resp_t;

    // Response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Address map
    // Offset widths count byte address bits within each window
    localparam addr_t SRAM_BASE_ADDR = 32'h0001_0000;
    localparam int    SRAM_ADDR_W    = 10;
    localparam addr_t FIFO_BASE_ADDR = 32'h0002_0000;
    localparam int    FIFO_ADDR_W    = 12;

    // FIFO depth in words
    localparam int FIFO_DEPTH = 16;

    // Outstanding limits per endpoint
    localparam int MAX_RD_OUTSTANDING = 2;
    localparam int MAX_WR_OUTSTANDING = 4;

endpackage
